//--- hdl/kp_pkg.sv
`default_nettype none

package kp_pkg;

    // Host port widths
    typedef logic [7:0]  addr_t;
    typedef logic [15:0] word_t;

    // Key position as column * 4 + row
    typedef logic [3:0] key_code_t;

    typedef logic [7:0] byte_t;

    // Column dwell is scan_div + 1 cycles
    typedef logic [7:0] scan_div_t;

    // Register map in host byte addresses
    localparam addr_t ADDR_KEY   = 8'h00;
    localparam addr_t ADDR_CFG   = 8'h04;
    localparam addr_t ADDR_DCMD  = 8'h08;
    localparam addr_t ADDR_DDATA = 8'h0C;

    typedef struct packed {
        addr_t addr;
        logic  we;
        word_t wdata;
    } host_req_t;

    // dcx low selects a command byte
    typedef struct packed {
        logic  dcx;
        byte_t data;
    } disp_xfer_t;

    // 8080-style screen pins
    typedef struct packed {
        logic  csx;
        logic  dcx;
        logic  wrx;
        byte_t data;
    } disp_bus_t;

endpackage

`default_nettype wire

//--- hdl/key_scanner.sv
`default_nettype none

module key_scanner (
    input  logic              clk,
    input  logic              rst,
    input  kp_pkg::scan_div_t scan_div,
    input  logic [3:0]        row,
    output logic [3:0]        column,
    output logic              key_event,
    output kp_pkg::key_code_t key_code
);

    logic [3:0]        row_meta;
    logic [3:0]        row_sync;
    kp_pkg::scan_div_t dwell_cnt;
    logic              dwell_end;
    logic              scan_end;
    logic              row_hit;
    logic              seen_cur;
    logic              seen_prev;
    logic [1:0]        col_idx;
    logic [1:0]        row_idx;

    // Two-flop synchroniser on the row inputs
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            row_meta <= '0;
            row_sync <= '0;
        end else begin
            row_meta <= row;
            row_sync <= row_meta;
        end
    end

    // A smaller scan_div written mid-dwell ends the dwell at once
    assign dwell_end = (dwell_cnt >= scan_div);
    assign scan_end  = dwell_end && column[3];
    assign row_hit   = |row_sync;

    // Dwell counter and one-hot column rotation
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            dwell_cnt <= '0;
            column    <= 4'b0001;
        end else if (dwell_end) begin
            dwell_cnt <= '0;
            column    <= {column[2:0], column[3]};
        end else begin
            dwell_cnt <= dwell_cnt + kp_pkg::scan_div_t'(1);
        end
    end

    // Column index from the one-hot drive
    always_comb begin
        case (column)
            4'b0010: col_idx = 2'd1;
            4'b0100: col_idx = 2'd2;
            4'b1000: col_idx = 2'd3;
            default: col_idx = 2'd0;
        endcase
    end

    // Lowest set row bit wins
    always_comb begin
        if (row_sync[0]) begin
            row_idx = 2'd0;
        end else if (row_sync[1]) begin
            row_idx = 2'd1;
        end else if (row_sync[2]) begin
            row_idx = 2'd2;
        end else begin
            row_idx = 2'd3;
        end
    end

    // seen_prev covers the last complete scan, seen_cur the one in progress
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            seen_cur  <= 1'b0;
            seen_prev <= 1'b0;
        end else if (scan_end) begin
            seen_prev <= seen_cur || row_hit;
            seen_cur  <= 1'b0;
        end else if (dwell_end && row_hit) begin
            seen_cur <= 1'b1;
        end
    end

    // Only a press after a clean scan makes an event
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            key_event <= 1'b0;
        end else begin
            key_event <= dwell_end && row_hit && !seen_prev && !seen_cur;
        end
    end

    always_ff @(posedge clk) begin
        if (dwell_end) begin
            key_code <= {col_idx, row_idx};
        end
    end

endmodule

`default_nettype wire

//--- hdl/periph_regs.sv
`default_nettype none

module periph_regs #(
    parameter kp_pkg::scan_div_t RESET_SCAN_DIV = 8'd3
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               req,
    input  kp_pkg::host_req_t  host_req,
    output logic               ack,
    output kp_pkg::word_t      rdata,
    input  logic               key_event,
    input  kp_pkg::key_code_t  key_code,
    output kp_pkg::scan_div_t  scan_div,
    output logic               disp_req,
    output kp_pkg::disp_xfer_t disp_xfer,
    input  logic               disp_ack
);

    kp_pkg::host_req_t host_q;
    logic              start;
    logic              decode;
    logic              is_disp;
    logic              is_cfg_wr;
    logic              key_read;
    logic              pending;
    kp_pkg::key_code_t code_q;
    kp_pkg::word_t     read_data;

    // Accept a request only once the previous access has fully closed
    assign start = req && !decode && !disp_req && !ack;

    assign is_disp = host_q.we &&
                     (host_q.addr == kp_pkg::ADDR_DCMD || host_q.addr == kp_pkg::ADDR_DDATA);
    assign is_cfg_wr = host_q.we && (host_q.addr == kp_pkg::ADDR_CFG);
    assign key_read  = decode && !host_q.we && (host_q.addr == kp_pkg::ADDR_KEY);

    always_ff @(posedge clk) begin
        if (start) begin
            host_q <= host_req;
        end
    end

    // Register read mux
    always_comb begin
        case (host_q.addr)
            kp_pkg::ADDR_KEY: read_data = kp_pkg::word_t'({pending, code_q});
            kp_pkg::ADDR_CFG: read_data = kp_pkg::word_t'(scan_div);
            default:          read_data = '0;
        endcase
    end

    // Host and display handshake control
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            decode   <= 1'b0;
            ack      <= 1'b0;
            disp_req <= 1'b0;
        end else begin
            decode <= start;
            if (decode) begin
                if (is_disp) begin
                    disp_req <= 1'b1;
                end else begin
                    ack <= 1'b1;
                end
            end else if (disp_req && disp_ack) begin
                // Screen cycle done so release the host
                disp_req <= 1'b0;
                ack      <= 1'b1;
            end else if (ack && !req) begin
                ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (decode) begin
            if (is_disp) begin
                disp_xfer.dcx  <= (host_q.addr == kp_pkg::ADDR_DDATA);
                disp_xfer.data <= host_q.wdata[7:0];
                rdata          <= '0;
            end else begin
                rdata <= host_q.we ? '0 : read_data;
            end
        end
    end

    // Configuration register
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            scan_div <= RESET_SCAN_DIV;
        end else if (decode && is_cfg_wr) begin
            scan_div <= host_q.wdata[7:0];
        end
    end

    // Key status where a new event beats a clearing read
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pending <= 1'b0;
            code_q  <= '0;
        end else if (key_event) begin
            pending <= 1'b1;
            code_q  <= key_code;
        end else if (key_read) begin
            pending <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/screen_writer.sv
`default_nettype none

module screen_writer #(
    parameter int unsigned WR_PULSE = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               disp_req,
    input  kp_pkg::disp_xfer_t disp_xfer,
    output logic               disp_ack,
    output kp_pkg::disp_bus_t  disp_bus
);

    localparam int CNT_W = (WR_PULSE > 1) ? $clog2(WR_PULSE) : 1;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SETUP,
        ST_LOW,
        ST_HIGH,
        ST_DONE
    } wr_state_t;

    wr_state_t        state;
    logic [CNT_W-1:0] pulse_cnt;
    logic             pulse_last;

    assign pulse_last = (pulse_cnt == CNT_W'(WR_PULSE - 1));

    // All pins come straight from flops
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state         <= ST_IDLE;
            pulse_cnt     <= '0;
            disp_ack      <= 1'b0;
            disp_bus.csx  <= 1'b1;
            disp_bus.dcx  <= 1'b0;
            disp_bus.wrx  <= 1'b1;
            disp_bus.data <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (disp_req) begin
                        // Select the chip and present dcx and data
                        disp_bus.csx  <= 1'b0;
                        disp_bus.dcx  <= disp_xfer.dcx;
                        disp_bus.data <= disp_xfer.data;
                        state         <= ST_SETUP;
                    end
                end
                ST_SETUP: begin
                    disp_bus.wrx <= 1'b0;
                    pulse_cnt    <= '0;
                    state        <= ST_LOW;
                end
                ST_LOW: begin
                    if (pulse_last) begin
                        // Screen latches on this rising edge
                        disp_bus.wrx <= 1'b1;
                        pulse_cnt    <= '0;
                        state        <= ST_HIGH;
                    end else begin
                        pulse_cnt <= pulse_cnt + CNT_W'(1);
                    end
                end
                ST_HIGH: begin
                    if (pulse_last) begin
                        disp_bus.csx <= 1'b1;
                        disp_ack     <= 1'b1;
                        state        <= ST_DONE;
                    end else begin
                        pulse_cnt <= pulse_cnt + CNT_W'(1);
                    end
                end
                ST_DONE: begin
                    // Hold ack until the request is withdrawn
                    if (!disp_req) begin
                        disp_ack <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/kp_periph_top.sv
`default_nettype none

module kp_periph_top #(
    parameter kp_pkg::scan_div_t RESET_SCAN_DIV = 8'd3,
    parameter int unsigned       WR_PULSE       = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  kp_pkg::host_req_t host_req,
    output logic              ack,
    output kp_pkg::word_t     rdata,
    input  logic [3:0]        row,
    output logic [3:0]        column,
    output kp_pkg::disp_bus_t disp_bus
);

    // Key link
    logic               key_event;
    kp_pkg::key_code_t  key_code;
    kp_pkg::scan_div_t  scan_div;

    // Display link
    logic               disp_req;
    kp_pkg::disp_xfer_t disp_xfer;
    logic               disp_ack;

    key_scanner i_key_scanner (
        .clk       (clk),
        .rst       (rst),
        .scan_div  (scan_div),
        .row       (row),
        .column    (column),
        .key_event (key_event),
        .key_code  (key_code)
    );

    periph_regs #(
        .RESET_SCAN_DIV (RESET_SCAN_DIV)
    ) i_periph_regs (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .host_req  (host_req),
        .ack       (ack),
        .rdata     (rdata),
        .key_event (key_event),
        .key_code  (key_code),
        .scan_div  (scan_div),
        .disp_req  (disp_req),
        .disp_xfer (disp_xfer),
        .disp_ack  (disp_ack)
    );

    screen_writer #(
        .WR_PULSE (WR_PULSE)
    ) i_screen_writer (
        .clk       (clk),
        .rst       (rst),
        .disp_req  (disp_req),
        .disp_xfer (disp_xfer),
        .disp_ack  (disp_ack),
        .disp_bus  (disp_bus)
    );

endmodule

`default_nettype wire

//--- dv/kp_periph_assertions.sv
`default_nettype none

module kp_periph_assertions (
    input logic clk,
    input logic rst,
    input logic req,
    input logic ack,
    input logic disp_req,
    input logic disp_ack,
    input logic csx,
    input logic wrx
);

    timeunit 1ns;
    timeprecision 1ps;

    // Four-phase host handshake
    ack_needs_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
        else $error("ack rose while req was low");
    ack_after_req_drop: assert property (@(posedge clk) disable iff (rst)
        $fell(ack) |-> !$past(req))
        else $error("ack fell before req dropped");

    // Strobe only inside a chip select
    wrx_inside_csx: assert property (@(posedge clk) disable iff (rst) !wrx |-> !csx)
        else $error("wrx low while csx high");

    disp_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(disp_ack) |-> disp_req)
        else $error("disp_ack rose while disp_req was low");

endmodule

// Host port, display link and screen pins all meet at the top level
bind kp_periph_top kp_periph_assertions i_assertions (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .ack      (ack),
    .disp_req (disp_req),
    .disp_ack (disp_ack),
    .csx      (disp_bus.csx),
    .wrx      (disp_bus.wrx)
);

`default_nettype wire

//--- dv/tb_kp_periph_top.sv
`default_nettype none

module tb_kp_periph_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam kp_pkg::scan_div_t RESET_SCAN_DIV = 8'd3;
    localparam int WR_PULSE = 2;
    localparam int DISP_LATENCY = 2 + 1 + 2 * WR_PULSE + 1 + 1;
    // Whole run stays under about 2000 cycles
    localparam int TIMEOUT_CYCLES = 20000;

    logic              clk;
    logic              rst;
    logic              req;
    kp_pkg::host_req_t host_req;
    logic              ack;
    kp_pkg::word_t     rdata;
    logic [3:0]        row;
    logic [3:0]        column;
    kp_pkg::disp_bus_t disp_bus;
    logic              bus_wrx;

    // Keypad model with a single key
    logic       key_down;
    logic [1:0] key_col;
    logic [1:0] key_row;

    int         cycle_cnt;
    int         scan_len;
    logic [8:0] bus_log[$];
    logic [8:0] bus_exp[$];

    kp_periph_top #(
        .RESET_SCAN_DIV (RESET_SCAN_DIV),
        .WR_PULSE       (WR_PULSE)
    ) i_dut (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .host_req (host_req),
        .ack      (ack),
        .rdata    (rdata),
        .row      (row),
        .column   (column),
        .disp_bus (disp_bus)
    );

    assign row = (key_down && column[key_col]) ? (4'b0001 << key_row) : 4'b0000;
    assign bus_wrx = disp_bus.wrx;

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Screen latches dcx and data on the rising edge of wrx
    always @(posedge bus_wrx) begin
        if (!rst) begin
            bus_log.push_back({disp_bus.dcx, disp_bus.data});
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Four-phase access that also counts the edges from req to ack
    task automatic host_access(input kp_pkg::addr_t address, input logic is_write,
                               input kp_pkg::word_t wr_data, output kp_pkg::word_t rd,
                               output int cycles);
        @(posedge clk);
        host_req <= '{addr: address, we: is_write, wdata: wr_data};
        req      <= 1'b1;
        cycles = 0;
        // Values read right after an edge are the ones settled before it
        do begin
            @(posedge clk);
            cycles++;
        end while (!ack);
        cycles = cycles - 1;
        rd = rdata;
        req <= 1'b0;
        do begin
            @(posedge clk);
        end while (ack);
    endtask

    task automatic host_write(input kp_pkg::addr_t address, input kp_pkg::word_t wr_data);
        kp_pkg::word_t rd;
        int            cycles;
        int            expect_cycles;
        expect_cycles = (address == kp_pkg::ADDR_DCMD || address == kp_pkg::ADDR_DDATA) ?
                        DISP_LATENCY : 2;
        host_access(address, 1'b1, wr_data, rd, cycles);
        check_eq(32'(cycles), 32'(expect_cycles), "write ack latency");
    endtask

    task automatic host_read(input kp_pkg::addr_t address, output kp_pkg::word_t rd);
        int cycles;
        host_access(address, 1'b0, '0, rd, cycles);
        check_eq(32'(cycles), 32'd2, "read ack latency");
    endtask

    task automatic press_key(input logic [1:0] col, input logic [1:0] rw);
        @(posedge clk);
        key_col  <= col;
        key_row  <= rw;
        key_down <= 1'b1;
    endtask

    task automatic release_key();
        @(posedge clk);
        key_down <= 1'b0;
    endtask

    task automatic wait_scans(input int n);
        repeat (n * scan_len) @(posedge clk);
    endtask

    task automatic reset_defaults();
        kp_pkg::word_t rd;
        check_eq(32'(ack), 32'd0, "ack after reset");
        check_eq(32'(disp_bus.csx), 32'd1, "csx after reset");
        check_eq(32'(disp_bus.wrx), 32'd1, "wrx after reset");
        check_eq(32'(column), 32'h1, "column after reset");
        host_read(kp_pkg::ADDR_CFG, rd);
        check_eq(32'(rd), 32'(RESET_SCAN_DIV), "scan_div after reset");
        host_read(kp_pkg::ADDR_KEY, rd);
        check_eq(32'(rd), 32'd0, "key register after reset");
    endtask

    task automatic scan_rate_config();
        kp_pkg::scan_div_t div;
        kp_pkg::word_t     rd;
        logic [3:0]        prev;
        int                n;
        // Dwell of at least three cycles keeps the synchronised row on its column
        div = kp_pkg::scan_div_t'($urandom_range(2, 7));
        host_write(kp_pkg::ADDR_CFG, kp_pkg::word_t'(div));
        host_read(kp_pkg::ADDR_CFG, rd);
        check_eq(32'(rd), 32'(div), "scan_div readback");
        scan_len = 4 * (int'(div) + 1);
        prev = column;
        do begin
            @(posedge clk);
        end while (column == prev);
        repeat (8) begin
            prev = column;
            n = 0;
            do begin
                @(posedge clk);
                n++;
            end while (column == prev);
            check_eq(32'(n), 32'(div) + 32'd1, "column dwell");
            check_eq(32'(column), 32'((prev == 4'b1000) ? 4'b0001 : (prev << 1)),
                     "column rotation");
        end
        // 0x34 shares its low bits with the configuration register
        host_write(8'h34, 16'hbeef);
        host_read(8'h34, rd);
        check_eq(32'(rd), 32'd0, "unmapped read");
        host_read(kp_pkg::ADDR_CFG, rd);
        check_eq(32'(rd), 32'(div), "scan_div after unmapped write");
    endtask

    task automatic capture_keys();
        logic [1:0]    col;
        logic [1:0]    rw;
        kp_pkg::word_t rd;
        repeat (5) begin
            col = 2'($urandom_range(0, 3));
            rw  = 2'($urandom_range(0, 3));
            press_key(col, rw);
            wait_scans(2);
            release_key();
            host_read(kp_pkg::ADDR_KEY, rd);
            check_eq(32'(rd), 32'h10 | (32'(col) * 4 + 32'(rw)), "key capture");
            host_read(kp_pkg::ADDR_KEY, rd);
            check_eq(32'(rd), 32'(col) * 4 + 32'(rw), "pending clear after read");
            // Room for one clean scan before the next press
            wait_scans(3);
        end
    endtask

    task automatic hold_gives_one_event();
        kp_pkg::word_t rd;
        press_key(2'd1, 2'd2);
        wait_scans(2);
        host_read(kp_pkg::ADDR_KEY, rd);
        check_eq(32'(rd), 32'h16, "first key event");
        wait_scans(6);
        host_read(kp_pkg::ADDR_KEY, rd);
        check_eq(32'(rd), 32'h06, "no repeat event while held");
        release_key();
        wait_scans(3);
        press_key(2'd3, 2'd0);
        wait_scans(2);
        release_key();
        host_read(kp_pkg::ADDR_KEY, rd);
        check_eq(32'(rd), 32'h1c, "second key replaces first");
        wait_scans(3);
    endtask

    task automatic screen_writes();
        logic          dcx;
        kp_pkg::byte_t data;
        repeat (8) begin
            dcx  = 1'($urandom_range(0, 1));
            data = kp_pkg::byte_t'($urandom);
            // High byte is noise the writer must ignore
            host_write(dcx ? kp_pkg::ADDR_DDATA : kp_pkg::ADDR_DCMD,
                       {kp_pkg::byte_t'($urandom), data});
            bus_exp.push_back({dcx, data});
        end
        check_eq(32'(bus_log.size()), 32'(bus_exp.size()), "screen write count");
        foreach (bus_exp[i]) begin
            check_eq(32'(bus_log[i]), 32'(bus_exp[i]), "screen dcx and data");
        end
    endtask

    initial begin
        void'($urandom(32'h644b));
        rst      = 1'b1;
        req      = 1'b0;
        host_req = '0;
        key_down = 1'b0;
        key_col  = '0;
        key_row  = '0;
        scan_len = 4 * (int'(RESET_SCAN_DIV) + 1);
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        reset_defaults();
        scan_rate_config();
        capture_keys();
        hold_gives_one_event();
        screen_writes();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
hdl/kp_pkg.sv
hdl/key_scanner.sv
hdl/periph_regs.sv
hdl/screen_writer.sv
hdl/kp_periph_top.sv
dv/kp_periph_assertions.sv
dv/tb_kp_periph_top.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -j 0 --top-module tb_kp_periph_top -f project.f \
    && ./obj_dir/Vtb_kp_periph_top \
    || { echo "simulation failed"; exit 1; }
